// ==== cpu16_decode.f ====
+incdir+testbench
design/cpu16_pkg.sv
design/reg_file.sv
design/ctrl_decode.sv
design/hazard_fsm.sv
design/id_unit.sv
design/id_ex_reg.sv
design/decode_stage.sv
testbench/decode_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decode_stage_tb
FILELIST  ?= cpu16_decode.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/decode_model.svh ====
// Reference model of the decode stage, included inside the testbench module
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [15:0]       shadow [16];  // Register file copy
logic              hold_pc;      // Waiting for a PC redirect
cpu16_pkg::id_ex_t held;         // Expected ID/EX content

function automatic cpu16_pkg::id_ex_t bubble_entry();
    cpu16_pkg::id_ex_t e;
    e             = '0;
    e.ctrl.alu_op = cpu16_pkg::alu_op_e'(3'b111);  // ALU no-op
    return e;
endfunction

// Control bits column by column from the instruction set
function automatic cpu16_pkg::ex_ctrl_t ctrl_of(input logic [3:0] op);
    cpu16_pkg::ex_ctrl_t c;
    logic [2:0]          alu;
    alu          = (op <= 4'h6) ? op[2:0] : (op inside {4'h7, 4'h8}) ? 3'b000 : 3'b111;
    c.reg_write  = (op <= 4'h7) || (op inside {4'h9, 4'ha});
    c.mem_write  = op inside {4'h8, 4'hc};    // Store, call pushes
    c.mem_read   = op inside {4'h7, 4'hd};    // Load, ret pops
    c.mem_to_reg = (op == 4'h7);
    c.alu_src    = op inside {[4'h4:4'ha]};   // Shift amount or offset
    c.alu_op     = cpu16_pkg::alu_op_e'(alu);
    c.branch     = (op == 4'hb);
    c.call       = (op == 4'hc);
    c.ret        = (op == 4'hd);
    c.load_half  = op inside {4'h9, 4'ha};
    c.half_spec  = (op == 4'ha);            // llb
    return c;
endfunction

// Port 1 reads DS for memory ops, SP for call and ret
function automatic logic [3:0] port1_of(input logic [15:0] ins);
    return (ins[15:12] inside {4'h7, 4'h8}) ? 4'd14 :
           (ins[15:12] inside {4'hc, 4'hd}) ? 4'd15 : ins[7:4];
endfunction

function automatic logic [3:0] port2_of(input logic [15:0] ins);
    return (ins[15:12] inside {[4'h8:4'ha]}) ? ins[11:8] : ins[3:0];  // sw, lhb, llb
endfunction

function automatic logic [15:0] read_reg(input logic [3:0] r);
    return (r == 4'd0) ? 16'h0000 : shadow[r];
endfunction

function automatic cpu16_pkg::id_ex_t decode_entry(input logic [15:0] ins,
                                                   input logic [15:0] at);
    cpu16_pkg::id_ex_t e;
    e.ctrl        = ctrl_of(ins[15:12]);
    e.read_data_1 = read_reg(port1_of(ins));
    e.read_data_2 = read_reg(port2_of(ins));
    e.sign_ext    = (ins[15:12] inside {[4'h7:4'hb]}) ? 16'($signed(ins[7:0]))
                                                    : 16'($signed(ins[3:0]));
    e.rd          = ins[11:8];
    e.branch_cond = ins[10:8];
    e.call_target = ins[11:0];
    e.pc          = at;
    return e;
endfunction

// Register still owed by an older instruction
function automatic logic busy(input logic [3:0] r, input logic [3:0] em_rd,
                              input logic em_we, input cpu16_pkg::wb_t w);
    return (r != 4'd0) && ((held.ctrl.reg_write && held.rd == r) ||
                           (em_we && em_rd == r) || (w.we && w.rd == r));
endfunction

function automatic logic hazard_of(input logic [15:0] ins, input logic [3:0] em_rd,
                                   input logic em_we, input cpu16_pkg::wb_t w);
    logic rs_use;
    logic rt_use;
    rs_use = (ins[15:12] <= 4'h8) || (ins[15:12] inside {4'hc, 4'hd});
    rt_use = (ins[15:12] <= 4'h3) || (ins[15:12] inside {[4'h8:4'ha]});
    return (rs_use && busy(port1_of(ins), em_rd, em_we, w)) ||
           (rt_use && busy(port2_of(ins), em_rd, em_we, w));
endfunction

`endif

// ==== testbench/decode_stage_tb.sv ====
// Self-checking testbench for decode_stage, seeded random instructions and write-backs
`timescale 1ns/10ps

module decode_stage_tb;

    localparam int n_writes    = 40;
    localparam int n_reads     = 40;
    localparam int n_clean     = 200;  // No outside writers
    localparam int n_mixed     = 200;  // Random EX/MEM and WB traffic
    localparam int n_callret   = 10;
    localparam int max_delay   = 8;    // Longest pc_update wait
    localparam int stim_cycles = 16 + 14 + n_writes + n_reads + n_clean + n_mixed
                                 + (n_callret + 1) * (max_delay + 3);
    localparam int cycle_limit = 4 * stim_cycles + 100;

    logic              clk;
    logic              rst;
    logic [15:0]       instr;
    logic [15:0]       pc;
    logic              instr_valid;
    cpu16_pkg::wb_t    wb;
    logic [3:0]        ex_mem_rd;
    logic              ex_mem_we;
    logic              pc_update;
    cpu16_pkg::id_ex_t id_ex;
    logic              stall;
    logic              pc_hazard;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int unsigned       seed_draw;
    logic              took;   // Word consumed on the last edge

    `include "decode_model.svh"

    decode_stage #(.SP_INIT(16'hffff)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: stimulus still running after %0d cycles", cycle_limit);
            $display("Checks %0d, errors %0d", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // One clock against the model, inputs already driven
    task automatic run_cycle(output logic consumed);
        logic dhaz;
        @(negedge clk);
        dhaz     = instr_valid && hazard_of(instr, ex_mem_rd, ex_mem_we, wb);
        consumed = instr_valid && !dhaz && !hold_pc;
        check_value("stall", 96'(stall), 96'(dhaz || hold_pc));
        check_value("pc_hazard", 96'(pc_hazard), 96'(hold_pc));
        hold_pc  = hold_pc ? !pc_update : (consumed && instr[15:12] inside {4'hc, 4'hd});
        held     = consumed ? decode_entry(instr, pc) : bubble_entry();
        if (wb.we && wb.rd != 4'd0) begin
            shadow[wb.rd] = wb.data;     // Lands at this edge
        end
        @(posedge clk);
        #1;
        check_value("id_ex", id_ex, held);
    endtask

    task automatic drive_traffic(input logic noisy);
        ex_mem_we = noisy && ($urandom_range(1, 0) == 1);
        ex_mem_rd = 4'($urandom_range(15, 0));
        wb.we     = noisy && ($urandom_range(1, 0) == 1);
        wb.rd     = 4'($urandom_range(15, 0));
        wb.data   = 16'($urandom);
    endtask

    // Fetch holds the word until the stage takes it
    task automatic issue(input logic [15:0] word, input logic noisy);
        instr       = word;
        instr_valid = 1'b1;
        do begin
            drive_traffic(noisy);
            run_cycle(took);
        end while (!took);
        pc          = pc + 16'd1;
        instr_valid = 1'b0;
    endtask

    function automatic logic [15:0] random_word(input logic with_flow);
        logic [15:0] w;
        do begin
            w = 16'($urandom);
        end while (!with_flow && w[15:12] inside {4'hc, 4'hd});
        return w;
    endfunction

    // Bubbles with a nop waiting until the PC updater answers
    task automatic await_redirect();
        int delay;
        delay       = $urandom_range(max_delay, 0);
        instr       = 16'he000;
        instr_valid = 1'b1;
        repeat (delay) run_cycle(took);
        pc_update = 1'b1;
        run_cycle(took);
        pc_update = 1'b0;
        check_value("pc_hazard", 96'(pc_hazard), 96'(0));
        check_value("stall", 96'(stall), 96'(0));
        issue(16'he000, 1'b0);
    endtask

    initial begin
        seed_draw   = $urandom(32'h7ba763ea);
        rst         = 1'b1;
        instr       = 16'h0000;
        pc          = 16'h0000;
        instr_valid = 1'b0;
        ex_mem_rd   = 4'd0;
        ex_mem_we   = 1'b0;
        pc_update   = 1'b0;
        wb          = '{we: 1'b1, rd: 4'd15, data: 16'h1234};  // Loses to the SP reset write
        hold_pc     = 1'b0;
        held        = bubble_entry();
        shadow[15]  = 16'hffff;
        repeat (16) @(posedge clk);
        #1;
        rst   = 1'b0;
        wb.we = 1'b0;
        check_value("id_ex", id_ex, held);
        check_value("stall", 96'(stall), 96'(0));
        check_value("pc_hazard", 96'(pc_hazard), 96'(0));
        issue(16'hd000, 1'b0);                  // ret reads SP
        check_value("id_ex.read_data_1", 96'(id_ex.read_data_1), 96'(16'hffff));
        await_redirect();
        for (int r = 1; r < 15; r++) begin
            wb = '{we: 1'b1, rd: 4'(r), data: 16'($urandom)};
            run_cycle(took);
        end
        repeat (n_writes) begin
            wb = '{we: 1'b1, rd: 4'($urandom), data: 16'($urandom)};  // r0 too
            run_cycle(took);
        end
        wb.we = 1'b0;
        repeat (n_reads) issue({8'h00, 8'($urandom)}, 1'b0);  // add into r0, pure reads
        repeat (n_clean) issue(random_word(1'b0), 1'b0);
        repeat (n_mixed) issue(random_word(1'b0), 1'b1);
        repeat (n_callret) begin
            issue({4'hc + 4'($urandom_range(1, 0)), 12'($urandom)}, 1'b0);
            await_redirect();
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/decode_stage.sv ====
// Top level of the cpu16 decode stage: decode unit feeding the ID/EX pipeline register
`timescale 1ns/10ps

module decode_stage #(
    parameter logic [15:0] SP_INIT = 16'hffff   // Stack pointer reset value
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [15:0]       instr,
    input  logic [15:0]       pc,
    input  logic              instr_valid,
    input  cpu16_pkg::wb_t    wb,
    input  logic [3:0]        ex_mem_rd,
    input  logic              ex_mem_we,
    input  logic              pc_update,
    output cpu16_pkg::id_ex_t id_ex,
    output logic              stall,
    output logic              pc_hazard
);

    cpu16_pkg::id_ex_t id_ex_next;
    logic              bubble;
    logic [3:0]        id_ex_rd;
    logic              id_ex_we;

    id_unit #(
        .SP_INIT (SP_INIT)
    ) u_id (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .wb          (wb),
        .ex_mem_rd   (ex_mem_rd),
        .ex_mem_we   (ex_mem_we),
        .id_ex_rd    (id_ex_rd),
        .id_ex_we    (id_ex_we),
        .pc_update   (pc_update),
        .id_ex_next  (id_ex_next),
        .bubble      (bubble),
        .stall       (stall),
        .pc_hazard   (pc_hazard)
    );

    // Destination loops back for the next compare
    id_ex_reg u_id_ex (
        .clk        (clk),
        .rst        (rst),
        .bubble     (bubble),
        .id_ex_next (id_ex_next),
        .id_ex      (id_ex),
        .id_ex_rd   (id_ex_rd),
        .id_ex_we   (id_ex_we)
    );

endmodule

// ==== design/id_ex_reg.sv ====
// ID/EX pipeline register; loads the decoded entry or a bubble and exposes its destination
`timescale 1ns/10ps

module id_ex_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              bubble,       // Hazard or no valid instruction
    input  cpu16_pkg::id_ex_t id_ex_next,
    output cpu16_pkg::id_ex_t id_ex,
    output logic [3:0]        id_ex_rd,     // To hazard compare
    output logic              id_ex_we
);

    // Held ID instruction stays at fetch, so no hold path is needed here
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            id_ex <= cpu16_pkg::id_ex_bubble;   // Zeroed fields, ALU no-op
        end else begin
            id_ex <= id_ex_next;
        end
    end

    // Bubble has reg_write clear, so it never matches
    assign id_ex_rd = id_ex.rd;
    assign id_ex_we = id_ex.ctrl.reg_write;

endmodule

// ==== design/id_unit.sv ====
// Decode datapath: splits the instruction, reads registers, extends immediates, flags bubbles
`timescale 1ns/10ps

module id_unit #(
    parameter logic [15:0] SP_INIT = 16'hffff
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [15:0]       instr,
    input  logic [15:0]       pc,
    input  logic              instr_valid,
    input  cpu16_pkg::wb_t    wb,
    input  logic [3:0]        ex_mem_rd,
    input  logic              ex_mem_we,
    input  logic [3:0]        id_ex_rd,    // Held ID/EX destination
    input  logic              id_ex_we,
    input  logic              pc_update,
    output cpu16_pkg::id_ex_t id_ex_next,
    output logic              bubble,
    output logic              stall,       // Back to fetch
    output logic              pc_hazard
);

    cpu16_pkg::opcode_e opcode;
    cpu16_pkg::ctrl_t   ctrl;
    logic [3:0]         ls_reg;       // [11:8] load/save or destination
    logic [3:0]         rs;           // [7:4]
    logic [3:0]         rt_field;     // [3:0], also the 4-bit immediate
    logic [7:0]         ls_imm;       // [7:0]
    logic [3:0]         rt_sel;
    logic [3:0]         rs_eff;       // Register port 1 really reads
    logic [15:0]        read_data_1;
    logic [15:0]        read_data_2;
    logic [15:0]        sign_ext;
    logic               arith_rr;
    logic               shift_op;
    logic               rs_used;
    logic               rt_used;
    logic               data_hazard;

    // Field split
    assign opcode   = cpu16_pkg::opcode_e'(instr[15:12]);
    assign ls_reg   = instr[11:8];
    assign rs       = instr[7:4];
    assign rt_field = instr[3:0];
    assign ls_imm   = instr[7:0];

    ctrl_decode u_ctrl (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    // Stores and half loads read rt from [11:8]
    assign rt_sel = ctrl.reg_rt_src ? ls_reg : rt_field;

    reg_file #(
        .SP_INIT (SP_INIT)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb          (wb),
        .data_reg    (ctrl.data_reg),
        .stack_reg   (ctrl.stack_reg),
        .rs          (rs),
        .rt          (rt_sel),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2)
    );

    // Source usage for hazard checks
    assign arith_rr = opcode inside {cpu16_pkg::op_add, cpu16_pkg::op_sub,
                                     cpu16_pkg::op_and, cpu16_pkg::op_nor};
    assign shift_op = opcode inside {cpu16_pkg::op_sll, cpu16_pkg::op_srl,
                                     cpu16_pkg::op_sra};
    assign rs_used  = arith_rr || shift_op || ctrl.data_reg || ctrl.stack_reg;
    assign rt_used  = arith_rr || ctrl.reg_rt_src;

    // DS and SP replace rs on port 1, compare what is read
    assign rs_eff = ctrl.data_reg  ? cpu16_pkg::reg_ds :
                    ctrl.stack_reg ? cpu16_pkg::reg_sp : rs;

    hazard_fsm u_hazard (
        .clk         (clk),
        .rst         (rst),
        .rs          (rs_eff),
        .rt          (rt_sel),
        .rt_used     (rt_used),
        .rs_used     (rs_used),
        .instr_valid (instr_valid),
        .is_call_ret (ctrl.ex.call || ctrl.ex.ret),
        .id_ex_rd    (id_ex_rd),
        .id_ex_we    (id_ex_we),
        .ex_mem_rd   (ex_mem_rd),
        .ex_mem_we   (ex_mem_we),
        .wb          (wb),
        .pc_update   (pc_update),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    // Sign extension, 8-bit load/save/branch or 4-bit arith immediate
    assign sign_ext = ctrl.sign_ext_sel ? {{8{ls_imm[7]}}, ls_imm}
                                        : {{12{rt_field[3]}}, rt_field};

    always_comb begin
        id_ex_next.ctrl        = ctrl.ex;      // ID-only bits dropped here
        id_ex_next.read_data_1 = read_data_1;
        id_ex_next.read_data_2 = read_data_2;
        id_ex_next.sign_ext    = sign_ext;
        id_ex_next.rd          = ls_reg;
        id_ex_next.branch_cond = instr[10:8];
        id_ex_next.call_target = instr[11:0];
        id_ex_next.pc          = pc;
    end

    assign stall  = data_hazard || pc_hazard;
    assign bubble = stall || !instr_valid;   // Nothing consumed this edge

endmodule

// ==== design/hazard_fsm.sv ====
// Data hazard detection and call/return PC hold state machine for the decode stage
`timescale 1ns/10ps

module hazard_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic [3:0]     rs,          // Effective port 1 register
    input  logic [3:0]     rt,          // Selected port 2 register
    input  logic           rt_used,
    input  logic           rs_used,
    input  logic           instr_valid,
    input  logic           is_call_ret,
    input  logic [3:0]     id_ex_rd,
    input  logic           id_ex_we,
    input  logic [3:0]     ex_mem_rd,
    input  logic           ex_mem_we,
    input  cpu16_pkg::wb_t wb,
    input  logic           pc_update,   // One-cycle pulse from PC updater
    output logic           data_hazard,
    output logic           pc_hazard
);

    typedef enum logic {
        RUN,
        HOLD_PC
    } state_t;

    state_t state;
    state_t state_next;
    logic   rs_hit;
    logic   rt_hit;

    // Any in-flight writer of this register
    function automatic logic in_flight(input logic [3:0] src);
        logic hit;
        hit = (id_ex_we && id_ex_rd == src) ||
              (ex_mem_we && ex_mem_rd == src) ||
              (wb.we && wb.rd == src);   // Written only at this edge
        return hit && (src != 4'd0);     // r0 never conflicts
    endfunction

    // Source matches against pending writers
    always_comb begin
        rs_hit = rs_used && in_flight(rs);
        rt_hit = rt_used && in_flight(rt);
    end

    assign data_hazard = instr_valid && (rs_hit || rt_hit);

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                // Consumed call or ret freezes fetch
                if (instr_valid && is_call_ret && !data_hazard) begin
                    state_next = HOLD_PC;
                end
            end
            HOLD_PC: begin
                if (pc_update) begin
                    state_next = RUN;
                end
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    assign pc_hazard = (state == HOLD_PC);

endmodule

// ==== design/ctrl_decode.sv ====
// Combinational opcode to control table for the decode stage, one row per opcode
`timescale 1ns/10ps

module ctrl_decode (
    input  cpu16_pkg::opcode_e opcode,
    output cpu16_pkg::ctrl_t   ctrl
);

    always_comb begin
        ctrl           = '0;                  // Defaults cover nop and hlt
        ctrl.ex.alu_op = cpu16_pkg::alu_nop;
        case (opcode)
            cpu16_pkg::op_add, cpu16_pkg::op_sub,
            cpu16_pkg::op_and, cpu16_pkg::op_nor: begin
                ctrl.ex.reg_write = 1'b1;
                ctrl.ex.alu_op    = cpu16_pkg::alu_op_e'(opcode[2:0]);  // Same encoding
            end
            cpu16_pkg::op_sll, cpu16_pkg::op_srl, cpu16_pkg::op_sra: begin
                ctrl.ex.reg_write = 1'b1;
                ctrl.ex.alu_src   = 1'b1;     // 4-bit shift amount
                ctrl.ex.alu_op    = cpu16_pkg::alu_op_e'(opcode[2:0]);
            end
            cpu16_pkg::op_lw: begin
                ctrl.ex.reg_write  = 1'b1;
                ctrl.ex.mem_read   = 1'b1;
                ctrl.ex.mem_to_reg = 1'b1;
                ctrl.ex.alu_src    = 1'b1;
                ctrl.ex.alu_op     = cpu16_pkg::alu_add;  // DS + offset
                ctrl.data_reg      = 1'b1;
                ctrl.sign_ext_sel  = 1'b1;
            end
            cpu16_pkg::op_sw: begin
                ctrl.ex.mem_write = 1'b1;
                ctrl.ex.alu_src   = 1'b1;
                ctrl.ex.alu_op    = cpu16_pkg::alu_add;
                ctrl.data_reg     = 1'b1;
                ctrl.reg_rt_src   = 1'b1;     // Store data from [11:8]
                ctrl.sign_ext_sel = 1'b1;
            end
            cpu16_pkg::op_lhb, cpu16_pkg::op_llb: begin
                ctrl.ex.reg_write = 1'b1;
                ctrl.ex.alu_src   = 1'b1;
                ctrl.ex.load_half = 1'b1;
                ctrl.ex.half_spec = (opcode == cpu16_pkg::op_llb);
                ctrl.reg_rt_src   = 1'b1;     // Old value keeps the other half
                ctrl.sign_ext_sel = 1'b1;
            end
            cpu16_pkg::op_b: begin
                ctrl.ex.branch    = 1'b1;
                ctrl.sign_ext_sel = 1'b1;     // 8-bit offset
            end
            cpu16_pkg::op_call: begin
                ctrl.ex.call      = 1'b1;
                ctrl.ex.mem_write = 1'b1;     // Push return address
                ctrl.stack_reg    = 1'b1;
            end
            cpu16_pkg::op_ret: begin
                ctrl.ex.ret      = 1'b1;
                ctrl.ex.mem_read = 1'b1;      // Pop return address
                ctrl.stack_reg   = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
// Register file of sixteen 16-bit registers for the decode stage, with SP reset write
`timescale 1ns/10ps

module reg_file #(
    parameter logic [15:0] SP_INIT = 16'hffff
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu16_pkg::wb_t    wb,          // Write-back port
    input  logic              data_reg,    // Port 1 forced to reg 14
    input  logic              stack_reg,   // Port 1 forced to reg 15
    input  logic [3:0]        rs,
    input  logic [3:0]        rt,
    output logic [15:0]       read_data_1,
    output logic [15:0]       read_data_2
);

    logic [15:0] regs [16];  // Entry 0 never written
    logic [3:0]  rd1_sel;    // Effective port 1 register

    // Writes at the edge; reset owns the port and only loads SP
    always_ff @(posedge clk) begin
        if (rst) begin
            regs[cpu16_pkg::reg_sp] <= SP_INIT;
        end else if (wb.we && wb.rd != 4'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Special register selection for port 1
    always_comb begin
        if (data_reg) begin
            rd1_sel = cpu16_pkg::reg_ds;
        end else if (stack_reg) begin
            rd1_sel = cpu16_pkg::reg_sp;
        end else begin
            rd1_sel = rs;
        end
    end

    // Combinational reads, r0 is hardwired zero
    assign read_data_1 = (rd1_sel == 4'd0) ? 16'h0000 : regs[rd1_sel];
    assign read_data_2 = (rt == 4'd0) ? 16'h0000 : regs[rt];

endmodule

// ==== design/cpu16_pkg.sv ====
// Shared opcodes, ALU codes, register numbers and pipeline structs; referenced by scoped name
package cpu16_pkg;

    // Instruction opcodes, bits [15:12] of the instruction word
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_nor  = 4'h3,
        op_sll  = 4'h4,
        op_srl  = 4'h5,
        op_sra  = 4'h6,
        op_lw   = 4'h7,
        op_sw   = 4'h8,
        op_lhb  = 4'h9,
        op_llb  = 4'ha,
        op_b    = 4'hb,
        op_call = 4'hc,
        op_ret  = 4'hd,
        op_nop  = 4'he,
        op_hlt  = 4'hf
    } opcode_e;

    // ALU operations; codes 0..6 line up with opcodes add..sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_nor = 3'b011,
        alu_sll = 3'b100,
        alu_srl = 3'b101,
        alu_sra = 3'b110,
        alu_nop = 3'b111  // Also the bubble code
    } alu_op_e;

    localparam logic [3:0] reg_ds = 4'd14;  // Data segment register
    localparam logic [3:0] reg_sp = 4'd15;  // Stack pointer

    // Control bits that travel on to EX and later, 13 bits
    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    alu_src;     // Immediate as ALU operand B
        alu_op_e alu_op;
        logic    branch;
        logic    call;
        logic    ret;
        logic    load_half;
        logic    half_spec;   // 0 -> lhb, 1 -> llb
    } ex_ctrl_t;

    // Full control word; the last four bits are used inside ID only
    typedef struct packed {
        ex_ctrl_t ex;
        logic     data_reg;     // Port 1 reads the data segment register
        logic     stack_reg;    // Port 1 reads the stack pointer
        logic     reg_rt_src;   // rt taken from the load/save register field
        logic     sign_ext_sel; // 1 -> 8-bit immediate, 0 -> 4-bit
    } ctrl_t;

    // ID/EX pipeline entry
    typedef struct packed {
        ex_ctrl_t    ctrl;
        logic [15:0] read_data_1;
        logic [15:0] read_data_2;
        logic [15:0] sign_ext;
        logic [3:0]  rd;          // Load/save or destination register
        logic [2:0]  branch_cond;
        logic [11:0] call_target;
        logic [15:0] pc;
    } id_ex_t;

    // Write-back port
    typedef struct packed {
        logic        we;
        logic [3:0]  rd;
        logic [15:0] data;
    } wb_t;

    // Bubble entry: no control, ALU no-op, data zero
    localparam id_ex_t id_ex_bubble = '{ctrl: '{alu_op: alu_nop, default: '0}, default: '0};

endpackage
